//--- rtl/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Processor address width in bits
`define CACHE_A_WIDTH 32

// Index bits of the direct-mapped cache, 64 lines
`define CACHE_C_INDEX 6

// Word address bits of the backing memory
`define MEM_AWIDTH 10

// Wait states before the memory ready pulse, must be at least 1
`define MEM_WAIT 3

// Width of each access counter
`define CNT_WIDTH 16

`endif

//--- rtl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    ////////////////////////////////////////
    // Cache to memory bus
    ////////////////////////////////////////

    // Operation on m_rw, encoded as in the processor p_rw bit
    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    // Tag bits left above index and byte offset
    localparam int T_WIDTH = `CACHE_A_WIDTH - `CACHE_C_INDEX - 2;

    ////////////////////////////////////////
    // Address word
    ////////////////////////////////////////

    // Same word seen whole or split for the cache lookup
    typedef union packed {
        logic [`CACHE_A_WIDTH-1:0] raw;
        struct packed {
            logic [T_WIDTH-1:0]        tag;
            logic [`CACHE_C_INDEX-1:0] index;
            logic [1:0]                offset;
        } fields;
    } cache_addr_u;

endpackage

`default_nettype wire

//--- rtl/d_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module d_cache (
    input  logic                      clk,
    input  logic                      clrn,
    // Processor side
    input  logic [`CACHE_A_WIDTH-1:0] p_a,
    input  logic [31:0]               p_dout,
    output logic [31:0]               p_din,
    input  logic                      p_strobe,
    input  logic                      p_rw,
    output logic                      p_ready,
    output logic                      cache_miss,
    // Memory side
    output logic [`CACHE_A_WIDTH-1:0] m_a,
    output logic [31:0]               m_din,
    input  logic [31:0]               m_dout,
    output logic                      m_strobe,
    output mem_bus_pkg::mem_op_e      m_rw,
    input  logic                      m_ready
);

    localparam int LINES = 1 << `CACHE_C_INDEX;

    cache_pkg::cache_addr_u addr;
    logic [`CACHE_C_INDEX-1:0] index;
    logic [cache_pkg::T_WIDTH-1:0] tag;

    // Line storage
    logic [LINES-1:0] d_valid;
    logic [cache_pkg::T_WIDTH-1:0] d_tags [LINES];
    logic [31:0] d_data [LINES];

    logic valid;
    logic [cache_pkg::T_WIDTH-1:0] tagout;
    logic [31:0] c_dout;
    logic [31:0] c_din;
    logic cache_hit;
    logic c_write;

    assign addr.raw = p_a;
    assign index = addr.fields.index;
    assign tag = addr.fields.tag;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign valid = d_valid[index];
    assign tagout = d_tags[index];
    assign c_dout = d_data[index];

    // Only reads can hit, every write goes out to memory
    assign cache_hit = valid & (tagout == tag) & p_strobe & ~p_rw;
    assign cache_miss = ~cache_hit & p_strobe;

    ////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////

    assign m_a = p_a;
    assign m_din = p_dout;
    assign m_strobe = p_strobe & (p_rw | cache_miss);
    assign m_rw = (p_strobe & p_rw) ? mem_bus_pkg::mem_write : mem_bus_pkg::mem_read;

    // Hit answers at once, the rest wait for the memory pulse
    assign p_ready = cache_hit | (m_strobe & m_ready);

    // Line update on the memory ready edge
    assign c_write = m_strobe & m_ready;
    assign c_din = p_rw ? p_dout : m_dout;
    assign p_din = cache_hit ? c_dout : m_dout;

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            d_valid <= '0;
        end else if (c_write) begin
            d_valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (c_write) begin
            d_tags[index] <= tag;
            d_data[index] <= c_din;
        end
    end

    ////////////////////////////////////////
    // Request checks
    ////////////////////////////////////////

    // Word accesses only
    a_word_aligned: assert property (
        @(posedge clk) disable iff (!clrn)
        p_strobe |-> addr.fields.offset == 2'b00
    ) else $error("d_cache: unaligned p_a %h", p_a);

    // Requester must hold everything until it sees ready
    a_req_stable: assert property (
        @(posedge clk) disable iff (!clrn)
        p_strobe && !p_ready |=>
            p_strobe && $stable(p_a) && $stable(p_rw) && $stable(p_dout)
    ) else $error("d_cache: request changed before p_ready");

endmodule

`default_nettype wire

//--- rtl/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module data_memory (
    input  logic                      clk,
    input  logic                      clrn,
    input  logic [`CACHE_A_WIDTH-1:0] m_a,
    input  logic [31:0]               m_din,
    output logic [31:0]               m_dout,
    input  logic                      m_strobe,
    input  mem_bus_pkg::mem_op_e      m_rw,
    output logic                      m_ready
);

    localparam int DEPTH = 1 << `MEM_AWIDTH;
    localparam int W_WIDTH = $clog2(`MEM_WAIT + 1);

    logic [31:0] mem [DEPTH];
    logic [`MEM_AWIDTH-1:0] word_addr;

    // Wait state tracking
    logic [W_WIDTH-1:0] wait_cnt;

    // Byte offset dropped, upper bits ignored
    assign word_addr = m_a[`MEM_AWIDTH+1:2];

    ////////////////////////////////////////
    // Contents
    ////////////////////////////////////////

    // Simulation image, each word holds its inverted index
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = ~32'(i);
        end
    end

    // Read data valid throughout the ready cycle
    assign m_dout = mem[word_addr];

    // Write lands on the ready edge
    always @(posedge clk) begin
        if (m_ready && m_rw == mem_bus_pkg::mem_write) begin
            mem[word_addr] <= m_din;
        end
    end

    ////////////////////////////////////////
    // Wait states
    ////////////////////////////////////////

    // First strobe cycle while idle is cycle 0
    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            wait_cnt <= '0;
        end else if (m_ready || !m_strobe) begin
            // Back to idle after the pulse or a dropped strobe
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign m_ready = (wait_cnt == W_WIDTH'(`MEM_WAIT));

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Pulse is a single cycle even with the strobe held
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!clrn)
        m_ready |=> !m_ready
    ) else $error("data_memory: m_ready high two cycles in a row");

endmodule

`default_nettype wire

//--- rtl/access_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module access_counter (
    input  logic                  clk,
    input  logic                  clrn,
    input  logic                  p_strobe,
    input  logic                  p_rw,
    input  logic                  p_ready,
    input  logic                  cache_miss,
    output logic [`CNT_WIDTH-1:0] hit_count,
    output logic [`CNT_WIDTH-1:0] miss_count,
    output logic [`CNT_WIDTH-1:0] write_count
);

    // An access completes on the edge that ends its ready cycle
    logic done;

    assign done = p_strobe & p_ready;

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////

    // Exactly one counter per completed access, all wrap
    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            hit_count   <= '0;
            miss_count  <= '0;
            write_count <= '0;
        end else if (done) begin
            if (p_rw) begin
                write_count <= write_count + 1'b1;
            end else if (cache_miss) begin
                // Read filled from memory
                miss_count <= miss_count + 1'b1;
            end else begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/cached_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cached_mem_top (
    input  logic                      clk,
    input  logic                      clrn,
    // Processor port
    input  logic [`CACHE_A_WIDTH-1:0] p_a,
    input  logic [31:0]               p_dout,
    output logic [31:0]               p_din,
    input  logic                      p_strobe,
    input  logic                      p_rw,
    output logic                      p_ready,
    output logic                      cache_miss,
    // Access statistics
    output logic [`CNT_WIDTH-1:0]     hit_count,
    output logic [`CNT_WIDTH-1:0]     miss_count,
    output logic [`CNT_WIDTH-1:0]     write_count
);

    // Cache to memory bus
    logic [`CACHE_A_WIDTH-1:0] m_a;
    logic [31:0]               m_din;
    logic [31:0]               m_dout;
    logic                      m_strobe;
    mem_bus_pkg::mem_op_e      m_rw;
    logic                      m_ready;

    d_cache i_d_cache (
        .clk        (clk),
        .clrn       (clrn),
        .p_a        (p_a),
        .p_dout     (p_dout),
        .p_din      (p_din),
        .p_strobe   (p_strobe),
        .p_rw       (p_rw),
        .p_ready    (p_ready),
        .cache_miss (cache_miss),
        .m_a        (m_a),
        .m_din      (m_din),
        .m_dout     (m_dout),
        .m_strobe   (m_strobe),
        .m_rw       (m_rw),
        .m_ready    (m_ready)
    );

    data_memory i_data_memory (
        .clk      (clk),
        .clrn     (clrn),
        .m_a      (m_a),
        .m_din    (m_din),
        .m_dout   (m_dout),
        .m_strobe (m_strobe),
        .m_rw     (m_rw),
        .m_ready  (m_ready)
    );

    // Watches the processor port only
    access_counter i_access_counter (
        .clk         (clk),
        .clrn        (clrn),
        .p_strobe    (p_strobe),
        .p_rw        (p_rw),
        .p_ready     (p_ready),
        .cache_miss  (cache_miss),
        .hit_count   (hit_count),
        .miss_count  (miss_count),
        .write_count (write_count)
    );

endmodule

`default_nettype wire

//--- testbench/tb_cached_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_cached_mem;

    localparam int TAG_W = `CACHE_A_WIDTH - `CACHE_C_INDEX - 2;
    localparam int LINES = 1 << `CACHE_C_INDEX;
    localparam int MEM_DEPTH = 1 << `MEM_AWIDTH;
    localparam int N_DIRECTED = 9;
    localparam int N_RANDOM = 300;
    localparam int WATCHDOG_CYCLES = 200 + (N_DIRECTED + N_RANDOM) * (`MEM_WAIT + 2);

    logic clk;
    logic clrn;
    logic [`CACHE_A_WIDTH-1:0] p_a;
    logic [31:0] p_dout;
    logic [31:0] p_din;
    logic p_strobe;
    logic p_rw;
    logic p_ready;
    logic cache_miss;
    logic [`CNT_WIDTH-1:0] hit_count;
    logic [`CNT_WIDTH-1:0] miss_count;
    logic [`CNT_WIDTH-1:0] write_count;

    // Reference model state
    logic [31:0] mem_model [MEM_DEPTH];
    logic [LINES-1:0] line_valid;
    logic [TAG_W-1:0] line_tag [LINES];
    logic exp_hit;
    logic [31:0] exp_rdata;
    logic [`CNT_WIDTH-1:0] exp_hits;
    logic [`CNT_WIDTH-1:0] exp_misses;
    logic [`CNT_WIDTH-1:0] exp_writes;
    int strobe_age;

    integer seed = 32'hc424_f040;

    cached_mem_top i_dut (
        .clk         (clk),
        .clrn        (clrn),
        .p_a         (p_a),
        .p_dout      (p_dout),
        .p_din       (p_din),
        .p_strobe    (p_strobe),
        .p_rw        (p_rw),
        .p_ready     (p_ready),
        .cache_miss  (cache_miss),
        .hit_count   (hit_count),
        .miss_count  (miss_count),
        .write_count (write_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    // Cycle number within the current request, 0 on its first strobe cycle
    always @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            strobe_age <= 0;
        end else if (!p_strobe || p_ready) begin
            strobe_age <= 0;
        end else begin
            strobe_age <= strobe_age + 1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_idle: assert property (
        @(posedge clk) disable iff (!clrn)
        !p_strobe |-> !p_ready && !cache_miss
    ) else stop_with_failure($sformatf("[FAIL] p_ready=%h cache_miss=%h with p_strobe low",
        $sampled(p_ready), $sampled(cache_miss)));

    a_miss_flag: assert property (
        @(posedge clk) disable iff (!clrn)
        p_strobe |-> cache_miss == !exp_hit
    ) else stop_with_failure($sformatf("[FAIL] cache_miss got %h expected %h",
        $sampled(cache_miss), $sampled(!exp_hit)));

    // Hits answer at once, the rest after exactly MEM_WAIT cycles
    a_ready_timing: assert property (
        @(posedge clk) disable iff (!clrn)
        p_strobe |-> p_ready == (exp_hit || strobe_age == `MEM_WAIT)
    ) else stop_with_failure($sformatf("[FAIL] p_ready got %h in cycle %h of the request",
        $sampled(p_ready), $sampled(strobe_age)));

    a_read_data: assert property (
        @(posedge clk) disable iff (!clrn)
        p_strobe && !p_rw && p_ready |-> p_din == exp_rdata
    ) else stop_with_failure($sformatf("[FAIL] p_din got %h expected %h",
        $sampled(p_din), $sampled(exp_rdata)));

    a_hit_count: assert property (
        @(posedge clk) disable iff (!clrn)
        hit_count == exp_hits
    ) else stop_with_failure($sformatf("[FAIL] hit_count got %h expected %h",
        $sampled(hit_count), $sampled(exp_hits)));

    a_miss_count: assert property (
        @(posedge clk) disable iff (!clrn)
        miss_count == exp_misses
    ) else stop_with_failure($sformatf("[FAIL] miss_count got %h expected %h",
        $sampled(miss_count), $sampled(exp_misses)));

    a_write_count: assert property (
        @(posedge clk) disable iff (!clrn)
        write_count == exp_writes
    ) else stop_with_failure($sformatf("[FAIL] write_count got %h expected %h",
        $sampled(write_count), $sampled(exp_writes)));

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Called 2 ns after a rising edge, returns 2 ns after the completing edge
    task automatic run_access(input logic rw, input logic [31:0] a, input logic [31:0] d);
        logic [`CACHE_C_INDEX-1:0] idx;
        logic [TAG_W-1:0] tag;
        logic [`MEM_AWIDTH-1:0] word;
        idx = a[`CACHE_C_INDEX+1:2];
        tag = a[`CACHE_A_WIDTH-1:`CACHE_C_INDEX+2];
        word = a[`MEM_AWIDTH+1:2];
        exp_hit = !rw && line_valid[idx] && line_tag[idx] == tag;
        exp_rdata = rw ? d : mem_model[word];
        p_a = a;
        p_rw = rw;
        p_dout = d;
        p_strobe = 1'b1;
        @(negedge clk);
        while (!p_ready) @(negedge clk);
        @(posedge clk);
        #2;
        if (rw) begin
            mem_model[word] = d;
            exp_writes = exp_writes + 1'b1;
        end else if (exp_hit) begin
            exp_hits = exp_hits + 1'b1;
        end else begin
            exp_misses = exp_misses + 1'b1;
        end
        if (!exp_hit) begin
            line_valid[idx] = 1'b1;
            line_tag[idx] = tag;
        end
        p_strobe = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("Timeout: the requests did not complete within the cycle limit");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        clrn = 1'b0;
        p_a = '0;
        p_dout = '0;
        p_strobe = 1'b0;
        p_rw = 1'b0;
        exp_hit = 1'b0;
        exp_rdata = '0;
        exp_hits = '0;
        exp_misses = '0;
        exp_writes = '0;
        line_valid = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_model[i] = ~32'(i);
        end
        repeat (8) @(posedge clk);
        #2;
        clrn = 1'b1;
        idle_cycles(3);

        // Cold miss, then a hit on the same word
        run_access(1'b0, 32'h0000_0100, '0);
        run_access(1'b0, 32'h0000_0100, '0);
        idle_cycles(1);
        // Write-through, then a hit on the written data
        run_access(1'b1, 32'h0000_0100, 32'h1234_5678);
        run_access(1'b0, 32'h0000_0100, '0);
        // Same index, other tag evicts the line
        run_access(1'b0, 32'h0000_0200, '0);
        run_access(1'b0, 32'h0000_0100, '0);
        run_access(1'b0, 32'h0000_0100, '0);
        idle_cycles(2);
        run_access(1'b1, 32'h0000_0200, 32'hcafe_0042);
        run_access(1'b0, 32'h0000_0200, '0);
        idle_cycles(2);

        // Random mix over 256 words, some with an aliasing upper bit
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = {22'd0, r[7:0], 2'b00};
            if (r[31:30] == 2'b11) begin
                a[20] = 1'b1;
            end
            run_access(r[9:8] == 2'b00, a, d);
            if (r[12]) begin
                idle_cycles(1);
            end
        end
        idle_cycles(2);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/cache_pkg.sv
rtl/d_cache.sv
rtl/data_memory.sv
rtl/access_counter.sv
rtl/cached_mem_top.sv
testbench/tb_cached_mem.sv

//--- Bender.yml
package:
  name: cached_mem

dependencies: {}

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_bus_pkg.sv
      - rtl/cache_pkg.sv
      - rtl/d_cache.sv
      - rtl/data_memory.sv
      - rtl/access_counter.sv
      - rtl/cached_mem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_cached_mem.sv
